// File: compile.f
+incdir+source
source/mem_tile_pkg.sv
source/sram_macro.sv
source/sram_bank_array.sv
source/port_arbiter.sv
source/narrow_upsizer.sv
source/mem_tile_top.sv
sim/mem_tile_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the memory tile testbench with Verilator, run it and check the log

rm -f sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module mem_tile_tb \
  -f compile.f -o mem_tile_sim \
  && ./obj_dir/mem_tile_sim 2>&1 | tee sim.log

grep -q "Simulation PASSED" sim.log \
  && echo "Run passed" \
  || { echo "Run failed, see sim.log"; exit 1; }

// File: sim/mem_tile_tb.sv
/*
 * Directed testbench of the memory tile
 * Reference memory model, compare tasks, xorshift stimulus and timeout
 */

`timescale 1ns/1ps

module mem_tile_tb
  import mem_tile_pkg::*;
();

  localparam int   CYCLE_LIMIT = 4000;
  localparam int   NUM_RANDOM  = 1800;
  localparam logic NARROW      = 1'b0;
  localparam logic WIDE        = 1'b1;
  localparam logic RD          = 1'b0;
  localparam logic WR          = 1'b1;

  logic         clk_i;
  logic         reset_i;
  logic         n_req_i;
  logic         n_we_i;
  tile_addr_t   n_addr_i;
  narrow_data_t n_wdata_i;
  narrow_strb_t n_be_i;
  logic         n_gnt_o;
  logic         n_rvalid_o;
  narrow_data_t n_rdata_o;
  logic         w_req_i;
  logic         w_we_i;
  tile_addr_t   w_addr_i;
  wide_data_t   w_wdata_i;
  wide_strb_t   w_be_i;
  logic         w_gnt_o;
  logic         w_rvalid_o;
  wide_data_t   w_rdata_o;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rng_state = 32'h2cb0;
  // SRAM model with one entry per wide word
  wide_data_t  ref_mem [int];
  // Accepted port per grant, 1 for wide
  logic        grant_log [$];

  mem_tile_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with tests still running", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_wide(input string name, input wide_data_t exp, input wide_data_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_narrow(input string name, input narrow_data_t exp,
                              input narrow_data_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One request on either port
  ////////////////////////////////////////////////////////////

  // Starts at a falling edge and returns at the falling edge of the response
  task automatic access(input string name, input logic wide, input logic we,
                        input tile_addr_t addr, input wide_data_t wdata,
                        input wide_strb_t be);
    int         key;
    logic       lane;
    wide_data_t old;
    wide_data_t mask;
    key  = int'(addr[11:3]);
    lane = addr[2];
    if (wide) begin
      w_req_i   = 1'b1;
      w_we_i    = we;
      w_addr_i  = addr;
      w_wdata_i = wdata;
      w_be_i    = be;
    end else begin
      n_req_i   = 1'b1;
      n_we_i    = we;
      n_addr_i  = addr;
      n_wdata_i = wdata[31:0];
      n_be_i    = be[3:0];
    end
    // Grant is looked at in the middle of the low phase
    #2;
    while (!(wide ? w_gnt_o : n_gnt_o)) begin
      @(negedge clk_i);
      #2;
    end
    @(posedge clk_i);
    grant_log.push_back(wide);
    old = ref_mem.exists(key) ? ref_mem[key] : '0;
    // Narrow data and enables move to the lane of address bit 2
    if (!wide) begin
      wdata = lane ? {wdata[31:0], 32'h0} : {32'h0, wdata[31:0]};
      be    = lane ? {be[3:0], 4'h0} : {4'h0, be[3:0]};
    end
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    if (we) begin
      ref_mem[key] = (old & ~mask) | (wdata & mask);
    end
    @(negedge clk_i);
    if (wide) begin
      w_req_i = 1'b0;
    end else begin
      n_req_i = 1'b0;
    end
    if (!(wide ? w_rvalid_o : n_rvalid_o)) begin
      errors++;
      $display("%s: rvalid did not arrive one cycle after the grant", name);
    end else if (!we && wide) begin
      check_wide(name, old, w_rdata_o);
    end else if (!we) begin
      check_narrow(name, lane ? old[63:32] : old[31:0], n_rdata_o);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  // Full write and read back of one wide word
  task automatic wide_write_read();
    access("wide write", WIDE, WR, 12'h040, 64'h0123_4567_89ab_cdef, 8'hff);
    access("wide read", WIDE, RD, 12'h040, '0, '0);
    @(negedge clk_i);
    check_bit("wide rvalid one cycle only", 1'b0, w_rvalid_o);
  endtask

  // Address bit 2 picks the lane
  task automatic narrow_lanes();
    access("lanes init", WIDE, WR, 12'h100, 64'h0, 8'hff);
    access("lanes low write", NARROW, WR, 12'h100, 64'hdead_beef, 8'h0f);
    access("lanes high write", NARROW, WR, 12'h104, 64'hcafe_f00d, 8'h0f);
    access("lanes wide read", WIDE, RD, 12'h100, '0, '0);
    access("lanes low read", NARROW, RD, 12'h100, '0, '0);
    access("lanes high read", NARROW, RD, 12'h104, '0, '0);
  endtask

  task automatic partial_writes();
    access("partial init", WIDE, WR, 12'h208, 64'h1111_2222_3333_4444, 8'hff);
    access("partial wide write", WIDE, WR, 12'h208, 64'haaaa_bbbb_cccc_dddd, 8'b1010_0101);
    access("partial narrow write", NARROW, WR, 12'h20c, 64'h5566_7788, 8'b0110);
    access("partial wide read", WIDE, RD, 12'h208, '0, '0);
    access("partial narrow read", NARROW, RD, 12'h20c, '0, '0);
  endtask

  // Bit 11 selects the macro row
  task automatic macro_rows();
    access("row 0 write", WIDE, WR, 12'h018, 64'h0000_0000_0000_aaaa, 8'hff);
    access("row 1 write", WIDE, WR, 12'h818, 64'h1111_1111_1111_bbbb, 8'hff);
    for (int i = 0; i < 6; i++) begin
      access("row read", WIDE, RD, i[0] ? 12'h818 : 12'h018, '0, '0);
    end
    access("row 1 narrow read", NARROW, RD, 12'h81c, '0, '0);
  endtask

  // Both ports request every cycle and grants alternate
  task automatic contested_grants();
    grant_log.delete();
    fork
      for (int i = 0; i < 4; i++) begin
        access("contested narrow", NARROW, RD, i[0] ? 12'h104 : 12'h20c, '0, '0);
      end
      for (int i = 0; i < 4; i++) begin
        access("contested wide", WIDE, RD, i[0] ? 12'h018 : 12'h818, '0, '0);
      end
    join
    for (int i = 0; i < 8; i++) begin
      check_bit("contested grant order", i[0], grant_log[i]);
    end
  endtask

  // Random mix over a pool of fully written words in both rows
  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] d_hi;
    logic [31:0] d_lo;
    tile_addr_t  addr;
    for (int i = 0; i < 16; i++) begin
      d_hi = next_rand();
      d_lo = next_rand();
      access("random init", WIDE, WR, {i[3], 2'b01, i[2:0], 6'b0}, {d_hi, d_lo}, 8'hff);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r    = next_rand();
      d_hi = next_rand();
      d_lo = next_rand();
      addr = {r[3], 2'b01, r[2:0], 3'b000, r[4] & ~r[5], 2'b00};
      access("random traffic", r[5], r[6], addr, {d_hi, d_lo}, r[15:8]);
    end
  endtask

  initial begin
    reset_i   = 1'b1;
    n_req_i   = 1'b0;
    n_we_i    = 1'b0;
    n_addr_i  = '0;
    n_wdata_i = '0;
    n_be_i    = '0;
    w_req_i   = 1'b0;
    w_we_i    = 1'b0;
    w_addr_i  = '0;
    w_wdata_i = '0;
    w_be_i    = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    wide_write_read();
    narrow_lanes();
    partial_writes();
    macro_rows();
    // Priority still holds its reset value here
    contested_grants();
    random_traffic();
    $display("Tests done with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: source/mem_tile_params.svh
/*
 * Global widths and bank geometry of the memory tile
 * Address field offsets used to slice the SRAM address
 */

`ifndef MEM_TILE_PARAMS_SVH
`define MEM_TILE_PARAMS_SVH

// Byte address and port widths
`define MT_ADDR_W            12
`define MT_WIDE_DATA_W       64
`define MT_NARROW_DATA_W     32

////////////////////////////////////////////////////////////
// Bank geometry
////////////////////////////////////////////////////////////

// Two 32-bit columns make up one wide word
`define MT_BANKS_PER_WORD    2
`define MT_BANK_ROWS         2
`define MT_MACRO_WORDS       256
`define MT_BANK_DATA_W       32

// Address fields
// Bits [2:0] are the byte offset inside a wide word
`define MT_MACRO_ADDR_OFFSET 3
`define MT_MACRO_SEL_OFFSET  11
`define MT_LANE_BIT          2

`endif

// File: source/mem_tile_pkg.sv
/*
 * Shared vector types of the memory tile
 * Priority encoding of the port arbiter
 */

`include "mem_tile_params.svh"

package mem_tile_pkg;

  // Request fields
  typedef logic [`MT_ADDR_W-1:0]          tile_addr_t;
  typedef logic [`MT_WIDE_DATA_W-1:0]     wide_data_t;
  typedef logic [`MT_WIDE_DATA_W/8-1:0]   wide_strb_t;
  typedef logic [`MT_NARROW_DATA_W-1:0]   narrow_data_t;
  typedef logic [`MT_NARROW_DATA_W/8-1:0] narrow_strb_t;

  ////////////////////////////////////////////////////////////
  // SRAM side
  ////////////////////////////////////////////////////////////

  // One bank column
  typedef logic [`MT_BANK_DATA_W-1:0]     bank_data_t;
  typedef logic [`MT_BANK_DATA_W/8-1:0]   bank_strb_t;

  // Word index inside one macro, and macro row index
  typedef logic [$clog2(`MT_MACRO_WORDS)-1:0] macro_addr_t;
  typedef logic [$clog2(`MT_BANK_ROWS)-1:0]   macro_sel_t;

  // Port that wins the next contested cycle
  typedef enum logic {
    PRIO_NARROW = 1'b0,
    PRIO_WIDE   = 1'b1
  } arb_prio_e;

endpackage

// File: source/mem_tile_top.sv
/*
 * mem_tile_top: narrow and wide requesters sharing one banked SRAM
 * through a round-robin arbiter
 */

`timescale 1ns/1ps

module mem_tile_top
  import mem_tile_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  // Narrow port
  input  logic         n_req_i,
  input  logic         n_we_i,
  input  tile_addr_t   n_addr_i,
  input  narrow_data_t n_wdata_i,
  input  narrow_strb_t n_be_i,
  output logic         n_gnt_o,
  output logic         n_rvalid_o,
  output narrow_data_t n_rdata_o,
  // Wide port
  input  logic         w_req_i,
  input  logic         w_we_i,
  input  tile_addr_t   w_addr_i,
  input  wide_data_t   w_wdata_i,
  input  wide_strb_t   w_be_i,
  output logic         w_gnt_o,
  output logic         w_rvalid_o,
  output wide_data_t   w_rdata_o
);

  // Upsized narrow request
  logic       up_req;
  logic       up_we;
  tile_addr_t up_addr;
  wide_data_t up_wdata;
  wide_strb_t up_be;
  logic       up_gnt;
  logic       up_rvalid;
  wide_data_t up_rdata;

  // Shared memory request
  logic       mem_req;
  logic       mem_we;
  tile_addr_t mem_addr;
  wide_data_t mem_wdata;
  wide_strb_t mem_be;
  wide_data_t mem_rdata;

  narrow_upsizer i_upsizer (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .n_req_i    (n_req_i),
    .n_we_i     (n_we_i),
    .n_addr_i   (n_addr_i),
    .n_wdata_i  (n_wdata_i),
    .n_be_i     (n_be_i),
    .n_gnt_o    (n_gnt_o),
    .n_rvalid_o (n_rvalid_o),
    .n_rdata_o  (n_rdata_o),
    .up_req_o   (up_req),
    .up_we_o    (up_we),
    .up_addr_o  (up_addr),
    .up_wdata_o (up_wdata),
    .up_be_o    (up_be),
    .up_gnt_i   (up_gnt),
    .up_rvalid_i(up_rvalid),
    .up_rdata_i (up_rdata)
  );

  port_arbiter i_arbiter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .a_req_i    (up_req),
    .a_we_i     (up_we),
    .a_addr_i   (up_addr),
    .a_wdata_i  (up_wdata),
    .a_be_i     (up_be),
    .a_gnt_o    (up_gnt),
    .a_rvalid_o (up_rvalid),
    .a_rdata_o  (up_rdata),
    .b_req_i    (w_req_i),
    .b_we_i     (w_we_i),
    .b_addr_i   (w_addr_i),
    .b_wdata_i  (w_wdata_i),
    .b_be_i     (w_be_i),
    .b_gnt_o    (w_gnt_o),
    .b_rvalid_o (w_rvalid_o),
    .b_rdata_o  (w_rdata_o),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_be_o   (mem_be),
    .mem_rdata_i(mem_rdata)
  );

  sram_bank_array i_banks (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mem_req_i  (mem_req),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wdata_i(mem_wdata),
    .mem_be_i   (mem_be),
    .mem_rdata_o(mem_rdata)
  );

endmodule

// File: source/narrow_upsizer.sv
/*
 * narrow_upsizer: places a 32-bit request on one lane of the wide bus
 * and returns the matching half of the wide read data
 */

`timescale 1ns/1ps

`include "mem_tile_params.svh"

module narrow_upsizer
  import mem_tile_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  // Narrow requester
  input  logic         n_req_i,
  input  logic         n_we_i,
  input  tile_addr_t   n_addr_i,
  input  narrow_data_t n_wdata_i,
  input  narrow_strb_t n_be_i,
  output logic         n_gnt_o,
  output logic         n_rvalid_o,
  output narrow_data_t n_rdata_o,
  // Wide-format request towards the arbiter
  output logic         up_req_o,
  output logic         up_we_o,
  output tile_addr_t   up_addr_o,
  output wide_data_t   up_wdata_o,
  output wide_strb_t   up_be_o,
  input  logic         up_gnt_i,
  input  logic         up_rvalid_i,
  input  wide_data_t   up_rdata_i
);

  logic lane;
  logic lane_q;

  assign lane = n_addr_i[`MT_LANE_BIT];

  // Request direction is purely combinational
  assign up_req_o  = n_req_i;
  assign up_we_o   = n_we_i;
  assign up_addr_o = {n_addr_i[`MT_ADDR_W-1:`MT_MACRO_ADDR_OFFSET],
                      {`MT_MACRO_ADDR_OFFSET{1'b0}}};

  // Unused lane gets zero data and no enables
  assign up_wdata_o = lane ? {n_wdata_i, narrow_data_t'('0)} : {narrow_data_t'('0), n_wdata_i};
  assign up_be_o    = lane ? {n_be_i, narrow_strb_t'('0)} : {narrow_strb_t'('0), n_be_i};

  assign n_gnt_o    = up_gnt_i;
  assign n_rvalid_o = up_rvalid_i;

  // Remember the lane until the response comes back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lane_q <= 1'b0;
    end else if (n_req_i && up_gnt_i) begin
      lane_q <= lane;
    end
  end

  assign n_rdata_o = lane_q ? up_rdata_i[`MT_WIDE_DATA_W-1:`MT_NARROW_DATA_W]
                            : up_rdata_i[`MT_NARROW_DATA_W-1:0];

  // Narrow accesses must not straddle a 32-bit word
  assert property (@(posedge clk_i) disable iff (reset_i)
    n_req_i |-> (n_addr_i[1:0] == 2'b00))
    else $error("Narrow request not 4-byte aligned: %h", n_addr_i);

endmodule

// File: source/port_arbiter.sv
/*
 * port_arbiter: round-robin grant between the narrow and wide requesters
 * Drives the shared SRAM request and steers responses back
 */

`timescale 1ns/1ps

module port_arbiter
  import mem_tile_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // Narrow side (already upsized)
  input  logic       a_req_i,
  input  logic       a_we_i,
  input  tile_addr_t a_addr_i,
  input  wide_data_t a_wdata_i,
  input  wide_strb_t a_be_i,
  output logic       a_gnt_o,
  output logic       a_rvalid_o,
  output wide_data_t a_rdata_o,
  // Wide side
  input  logic       b_req_i,
  input  logic       b_we_i,
  input  tile_addr_t b_addr_i,
  input  wide_data_t b_wdata_i,
  input  wide_strb_t b_be_i,
  output logic       b_gnt_o,
  output logic       b_rvalid_o,
  output wide_data_t b_rdata_o,
  // Shared memory request
  output logic       mem_req_o,
  output logic       mem_we_o,
  output tile_addr_t mem_addr_o,
  output wide_data_t mem_wdata_o,
  output wide_strb_t mem_be_o,
  input  wide_data_t mem_rdata_i
);

  arb_prio_e prio_q;
  logic      contested;
  logic      resp_valid_q;
  logic      resp_wide_q;

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////

  assign contested = a_req_i && b_req_i;

  // A lone requester always wins, otherwise the priority decides
  assign a_gnt_o = a_req_i && (!b_req_i || (prio_q == PRIO_NARROW));
  assign b_gnt_o = b_req_i && (!a_req_i || (prio_q == PRIO_WIDE));

  // Priority only moves on after a contested cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= PRIO_NARROW;
    end else if (contested) begin
      prio_q <= (prio_q == PRIO_NARROW) ? PRIO_WIDE : PRIO_NARROW;
    end
  end

  // Winner's fields onto the memory side
  assign mem_req_o   = a_gnt_o || b_gnt_o;
  assign mem_we_o    = b_gnt_o ? b_we_i    : a_we_i;
  assign mem_addr_o  = b_gnt_o ? b_addr_i  : a_addr_i;
  assign mem_wdata_o = b_gnt_o ? b_wdata_i : a_wdata_i;
  assign mem_be_o    = b_gnt_o ? b_be_i    : a_be_i;

  ////////////////////////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
      resp_wide_q  <= 1'b0;
    end else begin
      resp_valid_q <= mem_req_o;
      resp_wide_q  <= b_gnt_o;
    end
  end

  assign a_rvalid_o = resp_valid_q && !resp_wide_q;
  assign b_rvalid_o = resp_valid_q && resp_wide_q;
  assign a_rdata_o  = a_rvalid_o ? mem_rdata_i : '0;
  assign b_rdata_o  = b_rvalid_o ? mem_rdata_i : '0;

  // Only one port may own the memory in a cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(a_gnt_o && b_gnt_o))
    else $error("Both ports granted in the same cycle");

endmodule

// File: source/sram_bank_array.sv
/*
 * sram_bank_array: wide memory built from bank columns and macro rows
 * Row select is registered to pick the right macro for read data
 */

`timescale 1ns/1ps

`include "mem_tile_params.svh"

module sram_bank_array
  import mem_tile_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       mem_req_i,
  input  logic       mem_we_i,
  input  tile_addr_t mem_addr_i,
  input  wide_data_t mem_wdata_i,
  input  wide_strb_t mem_be_i,
  output wide_data_t mem_rdata_o
);

  localparam int unsigned BankBytes = `MT_BANK_DATA_W / 8;

  macro_addr_t macro_addr;
  macro_sel_t  macro_sel;
  macro_sel_t  macro_sel_q;

  bank_data_t bank_wdata [`MT_BANKS_PER_WORD];
  bank_strb_t bank_be    [`MT_BANKS_PER_WORD];
  bank_data_t rdata_split [`MT_BANK_ROWS][`MT_BANKS_PER_WORD];

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Same word index for every column of a row
  assign macro_addr = mem_addr_i[`MT_MACRO_ADDR_OFFSET +: $bits(macro_addr_t)];
  assign macro_sel  = mem_addr_i[`MT_MACRO_SEL_OFFSET +: $bits(macro_sel_t)];

  // Row of the last read, used when its data comes out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      macro_sel_q <= '0;
    end else if (mem_req_i && !mem_we_i) begin
      macro_sel_q <= macro_sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Column slicing
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MT_BANKS_PER_WORD; i++) begin : gen_columns
    assign bank_wdata[i] = mem_wdata_i[i*`MT_BANK_DATA_W +: `MT_BANK_DATA_W];
    assign bank_be[i]    = mem_be_i[i*BankBytes +: BankBytes];

    // Read data from the row that was addressed a cycle ago
    assign mem_rdata_o[i*`MT_BANK_DATA_W +: `MT_BANK_DATA_W] = rdata_split[macro_sel_q][i];
  end

  ////////////////////////////////////////////////////////////
  // Macros
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MT_BANKS_PER_WORD; i++) begin : gen_banks
    for (genvar j = 0; j < `MT_BANK_ROWS; j++) begin : gen_rows
      logic row_hit;

      // Only the selected row sees the request
      assign row_hit = mem_req_i && (macro_sel == macro_sel_t'(j));

      sram_macro #(
        .NumWords (`MT_MACRO_WORDS),
        .DataWidth(`MT_BANK_DATA_W)
      ) i_macro (
        .clk_i  (clk_i),
        .req_i  (row_hit),
        .we_i   (mem_we_i),
        .addr_i (macro_addr),
        .wdata_i(bank_wdata[i]),
        .be_i   (bank_be[i]),
        .rdata_o(rdata_split[j][i])
      );
    end
  end

  // Byte offset inside a wide word is handled by the enables
  assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i |-> (mem_addr_i[`MT_MACRO_ADDR_OFFSET-1:0] == '0))
    else $error("Memory request not word aligned: %h", mem_addr_i);

endmodule

// File: source/sram_macro.sv
/*
 * sram_macro: behavioral single-port SRAM with byte enables
 * Read data appears one cycle after the request
 */

`timescale 1ns/1ps

module sram_macro #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned DataWidth = 32
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NumWords)-1:0]  addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  input  logic [DataWidth/8-1:0]       be_i,
  output logic [DataWidth-1:0]         rdata_o
);

  logic [DataWidth-1:0] mem [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Byte-wise write, disabled bytes keep their value
        for (int b = 0; b < DataWidth/8; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule
